/* design/datapathPkg.sv */
package datapathPkg;

    // Data path word and register file sizes
    localparam int wordW    = 32;
    localparam int regCount = 16;
    localparam int regSelW  = 4;   // Index of R0 to R15

    // ALU operation codes, as driven on opcode
    localparam int opW = 5;

    localparam logic [opW-1:0] opAnd  = 5'd0;
    localparam logic [opW-1:0] opOr   = 5'd1;
    localparam logic [opW-1:0] opAdd  = 5'd2;
    localparam logic [opW-1:0] opSub  = 5'd3;
    localparam logic [opW-1:0] opShr  = 5'd4;
    localparam logic [opW-1:0] opShra = 5'd5;
    localparam logic [opW-1:0] opShl  = 5'd6;
    localparam logic [opW-1:0] opRor  = 5'd7;
    localparam logic [opW-1:0] opRol  = 5'd8;
    localparam logic [opW-1:0] opMul  = 5'd9;
    localparam logic [opW-1:0] opNeg  = 5'd10;
    localparam logic [opW-1:0] opNot  = 5'd11;
    localparam logic [opW-1:0] opInc  = 5'd12;
    localparam logic [opW-1:0] opNop  = 5'd13;

    // Bus sources, one out strobe each
    localparam int srcCount = 9;
    localparam int srcSelW  = $clog2(srcCount);

    localparam logic [srcSelW-1:0] srcReg    = 4'd0;
    localparam logic [srcSelW-1:0] srcHi     = 4'd1;
    localparam logic [srcSelW-1:0] srcLo     = 4'd2;
    localparam logic [srcSelW-1:0] srcZhigh  = 4'd3;
    localparam logic [srcSelW-1:0] srcZlow   = 4'd4;
    localparam logic [srcSelW-1:0] srcPc     = 4'd5;
    localparam logic [srcSelW-1:0] srcMdr    = 4'd6;
    localparam logic [srcSelW-1:0] srcInPort = 4'd7;
    localparam logic [srcSelW-1:0] srcConst  = 4'd8;

endpackage

/* design/instrPkg.sv */
package instrPkg;

    import datapathPkg::*;

    localparam int instrW  = 32;
    localparam int opcodeW = 5;
    localparam int constW  = instrW - opcodeW - 2 * regSelW;   // 19 bits

    // Three-register format, e.g. add ra, rb, rc
    typedef struct packed {
        logic [opcodeW-1:0]                   opcode;
        logic [regSelW-1:0]                   ra;
        logic [regSelW-1:0]                   rb;
        logic [regSelW-1:0]                   rc;
        logic [instrW-opcodeW-3*regSelW-1:0]  unused;
    } rFmtT;

    // Immediate format, rc and the tail become one constant
    typedef struct packed {
        logic [opcodeW-1:0] opcode;
        logic [regSelW-1:0] ra;
        logic [regSelW-1:0] rb;
        logic [constW-1:0]  constant;
    } iFmtT;

    // Same IR bits seen through either format
    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
    } instrWordT;

endpackage

/* design/memDataReg.sv */
`timescale 1ns/1ns

module memDataReg
    import datapathPkg::*;
(
    input  logic             Clock,
    input  logic             rstN,
    input  logic             read,
    input  logic             mdrIn,
    input  logic [wordW-1:0] inPortData,
    input  logic [wordW-1:0] busData,
    output logic [wordW-1:0] mdrData
);

    logic [wordW-1:0] mdrNext;
    logic [wordW-1:0] mdrReg;

    // Read selects the external word, otherwise MDR takes the bus
    assign mdrNext = read ? inPortData : busData;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            mdrReg <= '0;
        end else if (mdrIn) begin
            mdrReg <= mdrNext;
        end
    end

    assign mdrData = mdrReg;

endmodule

/* design/registerFile.sv */
`timescale 1ns/1ns

module registerFile
    import datapathPkg::*;
    import instrPkg::*;
(
    input  logic             Clock,
    input  logic             rstN,
    input  logic             gra,
    input  logic             grb,
    input  logic             grc,
    input  logic             regIn,
    input  logic             hiIn,
    input  logic             loIn,
    input  instrWordT        irWord,
    input  logic [wordW-1:0] busData,
    output logic [wordW-1:0] regData,
    output logic [wordW-1:0] hiData,
    output logic [wordW-1:0] loData
);

    logic [wordW-1:0]   regs [regCount];
    logic [wordW-1:0]   hiReg;
    logic [wordW-1:0]   loReg;
    logic [regSelW-1:0] regSel;

    // Select-and-encode, using the register view of IR
    // Each strobe gates one field, the OR gives the register index
    assign regSel = ({regSelW{gra}} & irWord.rFmt.ra)
                  | ({regSelW{grb}} & irWord.rFmt.rb)
                  | ({regSelW{grc}} & irWord.rFmt.rc);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regIn) begin
            regs[regSel] <= busData;
        end
    end

    // HI and LO have their own strobes, outside the select path
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (hiIn) hiReg <= busData;
            if (loIn) loReg <= busData;
        end
    end

    assign regData = regs[regSel];  // Always the selected register
    assign hiData  = hiReg;
    assign loData  = loReg;

endmodule

/* design/aluUnit.sv */
`timescale 1ns/1ns

module aluUnit
    import datapathPkg::*;
(
    input  logic             Clock,
    input  logic             rstN,
    input  logic             yIn,
    input  logic             zIn,
    input  logic             incPc,
    input  logic [opW-1:0]   opcode,
    input  logic [wordW-1:0] busData,
    output logic [wordW-1:0] zHigh,
    output logic [wordW-1:0] zLow
);

    logic [wordW-1:0]          yReg;
    logic [2*wordW-1:0]        zReg;
    logic [opW-1:0]            aluOp;
    logic [4:0]                shiftCnt;
    logic [2*wordW-1:0]        rotWord;
    logic signed [2*wordW-1:0] mulRes;
    logic [2*wordW-1:0]        aluRes;

    // PC increment overrides whatever is on opcode
    assign aluOp    = incPc ? opInc : opcode;
    assign shiftCnt = busData[4:0];  // Shift count from bus low bits
    assign rotWord  = {yReg, yReg};

    // Both operands signed, sized to 64 bits by the assignment
    assign mulRes = $signed(yReg) * $signed(busData);

    always_comb begin
        aluRes = '0;
        case (aluOp)
            opAnd:  aluRes[wordW-1:0] = yReg & busData;
            opOr:   aluRes[wordW-1:0] = yReg | busData;
            opAdd:  aluRes[wordW-1:0] = yReg + busData;  // Carry dropped
            opSub:  aluRes[wordW-1:0] = yReg - busData;
            opShr:  aluRes[wordW-1:0] = yReg >> shiftCnt;
            opShra: aluRes[wordW-1:0] = $signed(yReg) >>> shiftCnt;
            opShl:  aluRes[wordW-1:0] = yReg << shiftCnt;
            opRor: begin
                // Low half of the doubled word after a right shift
                aluRes[wordW-1:0] = 32'(rotWord >> shiftCnt);
            end
            opRol: begin
                aluRes[wordW-1:0] = 32'((rotWord << shiftCnt) >> wordW);
            end
            opMul:  aluRes = mulRes;
            opNeg:  aluRes[wordW-1:0] = -busData;   // Unary ops use the bus
            opNot:  aluRes[wordW-1:0] = ~busData;
            opInc:  aluRes[wordW-1:0] = busData + 1'b1;
            opNop:  aluRes[wordW-1:0] = busData;    // Pass-through
            default: aluRes = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            yReg <= '0;
        end else if (yIn) begin
            yReg <= busData;
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            zReg <= '0;
        end else if (zIn) begin
            zReg <= aluRes;
        end
    end

    assign zHigh = zReg[2*wordW-1:wordW];
    assign zLow  = zReg[wordW-1:0];

endmodule

/* design/fetchRegs.sv */
`timescale 1ns/1ns

module fetchRegs
    import datapathPkg::*;
    import instrPkg::*;
(
    input  logic             Clock,
    input  logic             rstN,
    input  logic             pcIn,
    input  logic             marIn,
    input  logic             irIn,
    input  logic [wordW-1:0] busData,
    output logic [wordW-1:0] pcData,
    output logic [wordW-1:0] marAddr,
    output instrWordT        irWord,
    output logic [wordW-1:0] constData
);

    logic [wordW-1:0] pcReg;
    logic [wordW-1:0] marReg;
    instrWordT        irReg;

    // PC, MAR and IR all load straight from the bus
    // The incremented PC arrives through Z low
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pcReg  <= '0;
            marReg <= '0;
            irReg  <= '0;
        end else begin
            if (pcIn)  pcReg  <= busData;
            if (marIn) marReg <= busData;
            if (irIn)  irReg  <= busData;
        end
    end

    // Immediate view of IR, constant sign-extended to a full word
    assign constData = {{(wordW - constW){irReg.iFmt.constant[constW-1]}},
                        irReg.iFmt.constant};

    assign pcData  = pcReg;
    assign marAddr = marReg;
    assign irWord  = irReg;

endmodule

/* design/busMux.sv */
`timescale 1ns/1ns

module busMux
    import datapathPkg::*;
(
    input  logic             regOut,
    input  logic             hiOut,
    input  logic             loOut,
    input  logic             zHighOut,
    input  logic             zLowOut,
    input  logic             pcOut,
    input  logic             mdrOut,
    input  logic             inPortOut,
    input  logic             cOut,
    input  logic [wordW-1:0] regData,
    input  logic [wordW-1:0] hiData,
    input  logic [wordW-1:0] loData,
    input  logic [wordW-1:0] zHigh,
    input  logic [wordW-1:0] zLow,
    input  logic [wordW-1:0] pcData,
    input  logic [wordW-1:0] mdrData,
    input  logic [wordW-1:0] inPortData,
    input  logic [wordW-1:0] constData,
    output logic [wordW-1:0] busData
);

    logic [srcCount-1:0] outStrobes;
    logic [srcSelW-1:0]  srcSel;
    logic                anyOut;

    always_comb begin
        outStrobes            = '0;
        outStrobes[srcReg]    = regOut;
        outStrobes[srcHi]     = hiOut;
        outStrobes[srcLo]     = loOut;
        outStrobes[srcZhigh]  = zHighOut;
        outStrobes[srcZlow]   = zLowOut;
        outStrobes[srcPc]     = pcOut;
        outStrobes[srcMdr]    = mdrOut;
        outStrobes[srcInPort] = inPortOut;
        outStrobes[srcConst]  = cOut;
    end

    // One-hot to index, highest strobe wins if several are set
    always_comb begin
        srcSel = '0;
        anyOut = 1'b0;
        for (int i = 0; i < srcCount; i++) begin
            if (outStrobes[i]) begin
                srcSel = srcSelW'(i);
                anyOut = 1'b1;
            end
        end
    end

    always_comb begin
        busData = '0;   // Idle bus reads zero
        if (anyOut) begin
            case (srcSel)
                srcReg:    busData = regData;
                srcHi:     busData = hiData;
                srcLo:     busData = loData;
                srcZhigh:  busData = zHigh;
                srcZlow:   busData = zLow;
                srcPc:     busData = pcData;
                srcMdr:    busData = mdrData;
                srcInPort: busData = inPortData;
                srcConst:  busData = constData;
                default:   busData = '0;
            endcase
        end
    end

endmodule

/* design/singleBusDatapath.sv */
`timescale 1ns/1ns

module singleBusDatapath
    import datapathPkg::*;
(
    input  logic             Clock,
    input  logic             rstN,
    // Out strobes
    input  logic             regOut,
    input  logic             hiOut,
    input  logic             loOut,
    input  logic             zHighOut,
    input  logic             zLowOut,
    input  logic             pcOut,
    input  logic             mdrOut,
    input  logic             inPortOut,
    input  logic             cOut,
    // In strobes
    input  logic             regIn,
    input  logic             hiIn,
    input  logic             loIn,
    input  logic             yIn,
    input  logic             zIn,
    input  logic             pcIn,
    input  logic             incPc,
    input  logic             marIn,
    input  logic             irIn,
    input  logic             mdrIn,
    input  logic             read,
    input  logic             gra,         // Register field select
    input  logic             grb,
    input  logic             grc,
    input  logic [opW-1:0]   opcode,
    input  logic [wordW-1:0] inPortData,
    output logic [wordW-1:0] busData,
    output logic [wordW-1:0] marAddr,
    output logic [wordW-1:0] irWord
);

    logic [wordW-1:0] mdrData;
    logic [wordW-1:0] regData, hiData, loData;
    logic [wordW-1:0] zHigh, zLow;
    logic [wordW-1:0] pcData, constData;

    memDataReg memDataReg_inst (
        .Clock, .rstN, .read, .mdrIn, .inPortData, .busData, .mdrData
    );

    registerFile registerFile_inst (
        .Clock, .rstN, .gra, .grb, .grc, .regIn, .hiIn, .loIn,
        .irWord, .busData, .regData, .hiData, .loData
    );

    aluUnit aluUnit_inst (
        .Clock, .rstN, .yIn, .zIn, .incPc, .opcode, .busData, .zHigh, .zLow
    );

    fetchRegs fetchRegs_inst (
        .Clock, .rstN, .pcIn, .marIn, .irIn, .busData,
        .pcData, .marAddr, .irWord, .constData
    );

    // Sole driver of the shared bus
    busMux busMux_inst (
        .regOut, .hiOut, .loOut, .zHighOut, .zLowOut, .pcOut, .mdrOut,
        .inPortOut, .cOut,
        .regData, .hiData, .loData, .zHigh, .zLow, .pcData, .mdrData,
        .inPortData, .constData, .busData
    );

endmodule

/* dv/datapath_chk.sv */
`timescale 1ns/1ns

module datapathChk
    import datapathPkg::*;
(
    input logic             Clock,
    input logic             rstN,
    input logic             regOut,
    input logic             hiOut,
    input logic             loOut,
    input logic             zHighOut,
    input logic             zLowOut,
    input logic             pcOut,
    input logic             mdrOut,
    input logic             inPortOut,
    input logic             cOut,
    input logic             pcIn,
    input logic [wordW-1:0] busData,
    input logic [wordW-1:0] pcData
);

    int                  failCount = 0;
    logic [srcCount-1:0] outStrobes;

    assign outStrobes = {regOut, hiOut, loOut, zHighOut, zLowOut,
                         pcOut, mdrOut, inPortOut, cOut};

    // Single bus, so at most one source at a time
    outStrobeOneHot: assert property (@(posedge Clock) disable iff (!rstN)
        $onehot0(outStrobes))
        else begin
            $error("more than one out strobe high");
            failCount++;
        end

    idleBusZero: assert property (@(posedge Clock) disable iff (!rstN)
        (outStrobes == '0) |-> (busData == '0))
        else begin
            $error("bus not zero with no out strobe");
            failCount++;
        end

    pcLoadsBus: assert property (@(posedge Clock) disable iff (!rstN)
        pcIn |=> (pcData == $past(busData)))  // Bus value one edge later
        else begin
            $error("PC did not take the bus value");
            failCount++;
        end

endmodule

bind singleBusDatapath datapathChk datapathChk_inst (
    .Clock, .rstN, .regOut, .hiOut, .loOut, .zHighOut, .zLowOut,
    .pcOut, .mdrOut, .inPortOut, .cOut, .pcIn, .busData, .pcData
);

/* dv/datapathTb.sv */
`timescale 1ns/1ns

module datapathTb
    import datapathPkg::*;
();

    logic               Clock;
    logic               rstN;
    logic               regOut, hiOut, loOut, zHighOut, zLowOut;
    logic               pcOut, mdrOut, inPortOut, cOut;
    logic               regIn, hiIn, loIn, yIn, zIn, pcIn, incPc;
    logic               marIn, irIn, mdrIn, read;
    logic               gra, grb, grc;
    logic [opW-1:0]     opcode;
    logic [wordW-1:0]   inPortData;
    logic [wordW-1:0]   busData, marAddr, irWord;

    // Reference model state
    logic [wordW-1:0]   regModel [regCount];
    logic [wordW-1:0]   irModel;
    logic [2*wordW-1:0] zModel;

    singleBusDatapath singleBusDatapath_inst (.*);

    initial Clock = 1'b0;
    always #4 Clock = ~Clock;

    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge Clock);
        #1;
        rstN = 1'b1;
    end

    initial begin
        #100000;
        reportTimeout("test sequence did not finish within 100 us");
    end

    task automatic reportMismatch(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic reportTimeout(input string msg);
        $display("Timeout: %s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic clearStrobes();
        {regOut, hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut} = '0;
        {regIn, hiIn, loIn, yIn, zIn, pcIn, incPc, marIn, irIn, mdrIn, read} = '0;
        {gra, grb, grc} = '0;
        opcode = opNop;
    endtask

    // One control step, inputs change just after the edge
    task automatic beginStep();
        @(posedge Clock);
        #1;
        clearStrobes();
    endtask

    task automatic checkBus(input logic [wordW-1:0] exp, input string what);
        #1;
        assert (busData === exp)
            else reportMismatch($sformatf("%s: bus %h, expected %h", what, busData, exp));
    endtask

    task automatic selectField(input int which);
        gra = (which == 0);
        grb = (which == 1);
        grc = (which == 2);
    endtask

    // ra, rb, rc fields of the register format
    function automatic logic [regSelW-1:0] fieldIndex(input int which);
        case (which)
            0:       return irModel[26:23];
            1:       return irModel[22:19];
            default: return irModel[18:15];
        endcase
    endfunction

    function automatic logic [2*wordW-1:0] aluModel(input logic [opW-1:0] op,
                                                    input logic [wordW-1:0] y,
                                                    input logic [wordW-1:0] b);
        logic signed [2*wordW-1:0] ys;
        logic signed [2*wordW-1:0] bs;
        logic [2*wordW-1:0]        res;
        logic [4:0]                n;
        n   = b[4:0];
        ys  = $signed(y);
        bs  = $signed(b);
        res = '0;
        case (op)
            opAnd:  res[wordW-1:0] = y & b;
            opOr:   res[wordW-1:0] = y | b;
            opAdd:  res[wordW-1:0] = y + b;
            opSub:  res[wordW-1:0] = y - b;
            opShr:  res[wordW-1:0] = y >> n;
            opShra: res[wordW-1:0] = (y >> n) | ({wordW{y[wordW-1]}} & ~({wordW{1'b1}} >> n));
            opShl:  res[wordW-1:0] = y << n;
            opRor:  res[wordW-1:0] = (y >> n) | (y << (wordW - n));
            opRol:  res[wordW-1:0] = (y << n) | (y >> (wordW - n));
            opMul:  res = ys * bs;
            opNeg:  res[wordW-1:0] = ~b + 1;
            opNot:  res[wordW-1:0] = ~b;
            opInc:  res[wordW-1:0] = b + 1;
            opNop:  res[wordW-1:0] = b;
            default: res = '0;
        endcase
        return res;
    endfunction

    task automatic loadIr(input logic [wordW-1:0] word);
        beginStep();
        inPortData = word;
        read       = 1'b1;
        mdrIn      = 1'b1;
        beginStep();
        mdrOut = 1'b1;
        irIn   = 1'b1;
        checkBus(word, "IR word through MDR");
        irModel = word;
        beginStep();
        assert (irWord === word)
            else reportMismatch($sformatf("IR %h, expected %h", irWord, word));
    endtask

    task automatic loadReg(input int which, input logic [wordW-1:0] value);
        beginStep();
        inPortData = value;
        read       = 1'b1;
        mdrIn      = 1'b1;
        beginStep();
        mdrOut = 1'b1;
        regIn  = 1'b1;
        selectField(which);
        checkBus(value, "register word through MDR");
        regModel[fieldIndex(which)] = value;
    endtask

    task automatic readReg(input int which, input string what);
        beginStep();
        regOut = 1'b1;
        selectField(which);
        checkBus(regModel[fieldIndex(which)], what);
    endtask

    // rb to Y, rc with the operation into Z, Z low back into ra
    task automatic aluStep(input logic [opW-1:0] op);
        logic [2*wordW-1:0] expZ;
        expZ = aluModel(op, regModel[fieldIndex(1)], regModel[fieldIndex(2)]);
        beginStep();
        regOut = 1'b1;
        grb    = 1'b1;
        yIn    = 1'b1;
        checkBus(regModel[fieldIndex(1)], "rb operand into Y");
        beginStep();
        regOut = 1'b1;
        grc    = 1'b1;
        opcode = op;
        zIn    = 1'b1;
        checkBus(regModel[fieldIndex(2)], "rc operand into ALU");
        zModel = expZ;
        beginStep();
        zLowOut = 1'b1;
        regIn   = 1'b1;
        gra     = 1'b1;
        checkBus(zModel[wordW-1:0], $sformatf("Z low for opcode %0d", op));
        regModel[fieldIndex(0)] = zModel[wordW-1:0];
        if (op == opMul) begin
            beginStep();
            zHighOut = 1'b1;
            checkBus(zModel[2*wordW-1:wordW], "Z high of multiply");
        end
        readReg(0, $sformatf("ra after opcode %0d", op));
    endtask

    initial begin
        logic [wordW-1:0] oldPc;
        logic [wordW-1:0] hiExp;
        logic [wordW-1:0] loExp;
        logic [18:0]      immValue;
        int               waitCycles;
        void'($urandom(32'h590b7f45));
        clearStrobes();
        inPortData = '0;
        irModel    = '0;
        zModel     = '0;
        for (int i = 0; i < regCount; i++) begin
            regModel[i] = '0;
        end

        waitCycles = 0;
        while (rstN !== 1'b1) begin
            @(posedge Clock);
            waitCycles++;
            if (waitCycles > 20) reportTimeout("reset was never released");
        end

        // Everything reads zero after reset
        #2;
        assert (marAddr === '0 && irWord === '0)
            else reportMismatch("MAR or IR not zero after reset");
        beginStep();
        hiOut = 1'b1;
        checkBus('0, "HI after reset");
        beginStep();
        loOut = 1'b1;
        checkBus('0, "LO after reset");
        beginStep();
        pcOut = 1'b1;
        checkBus('0, "PC after reset");
        beginStep();
        zHighOut = 1'b1;
        checkBus('0, "Z high after reset");
        beginStep();
        zLowOut = 1'b1;
        checkBus('0, "Z low after reset");
        for (int i = 0; i < regCount; i++) begin
            loadIr({5'd0, 4'(i), 23'd0});
            readReg(0, $sformatf("R%0d after reset", i));
        end

        // Inport loads into ra, rb and rc
        loadIr({5'd0, 4'd3, 4'd5, 4'd7, 15'd0});
        for (int f = 0; f < 3; f++) begin
            loadReg(f, $urandom());
        end
        for (int f = 0; f < 3; f++) begin
            readReg(f, "register loaded from inport");
        end

        for (int op = opAnd; op <= opNop; op++) begin
            loadReg(1, $urandom());
            loadReg(2, $urandom());
            aluStep(opW'(op));
        end

        // HI and LO from a multiply, held across later ALU steps
        loadReg(1, $urandom());
        loadReg(2, $urandom());
        aluStep(opMul);
        hiExp = zModel[2*wordW-1:wordW];
        loExp = zModel[wordW-1:0];
        beginStep();
        zHighOut = 1'b1;
        hiIn     = 1'b1;
        checkBus(hiExp, "Z high into HI");
        beginStep();
        zLowOut = 1'b1;
        loIn    = 1'b1;
        checkBus(loExp, "Z low into LO");
        aluStep(opAdd);
        aluStep(opSub);
        beginStep();
        hiOut = 1'b1;
        checkBus(hiExp, "HI after later ALU steps");
        beginStep();
        loOut = 1'b1;
        checkBus(loExp, "LO after later ALU steps");

        // Fetch step
        oldPc = $urandom();
        beginStep();
        inPortOut  = 1'b1;
        inPortData = oldPc;
        pcIn       = 1'b1;
        checkBus(oldPc, "inport into PC");
        beginStep();
        pcOut = 1'b1;
        marIn = 1'b1;
        incPc = 1'b1;
        zIn   = 1'b1;
        checkBus(oldPc, "PC on bus in fetch");
        beginStep();
        zLowOut = 1'b1;
        pcIn    = 1'b1;
        checkBus(oldPc + 1, "incremented PC from Z low");
        beginStep();
        pcOut = 1'b1;
        checkBus(oldPc + 1, "PC after fetch");
        assert (marAddr === oldPc)
            else reportMismatch($sformatf("MAR %h, expected %h", marAddr, oldPc));

        // Immediate view, negative then positive constant
        immValue = 19'h4_8a31;
        loadIr({5'd0, 4'd1, 4'd2, immValue});
        beginStep();
        cOut = 1'b1;
        checkBus({{13{immValue[18]}}, immValue}, "negative constant");
        immValue = 19'h2_35c7;
        loadIr({5'd0, 4'd1, 4'd2, immValue});
        beginStep();
        cOut = 1'b1;
        checkBus({{13{immValue[18]}}, immValue}, "positive constant");

        loadIr({5'd0, 4'd9, 4'd10, 4'd11, 15'd0});
        for (int f = 0; f < 3; f++) begin
            loadReg(f, $urandom());
        end
        for (int f = 0; f < 3; f++) begin
            readReg(f, "register view select");
        end

        beginStep();
        beginStep();
        if (singleBusDatapath_inst.datapathChk_inst.failCount == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("Bound checker saw %0d assertion failures",
                     singleBusDatapath_inst.datapathChk_inst.failCount);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

endmodule

/* compile.f */
design/datapathPkg.sv
design/instrPkg.sv
design/memDataReg.sv
design/registerFile.sv
design/aluUnit.sv
design/fetchRegs.sv
design/busMux.sv
design/singleBusDatapath.sv
dv/datapath_chk.sv
dv/datapathTb.sv

/* Bender.yml */
package:
  name: single_bus_datapath

sources:
  - files:
      - design/datapathPkg.sv
      - design/instrPkg.sv
      - design/memDataReg.sv
      - design/registerFile.sv
      - design/aluUnit.sv
      - design/fetchRegs.sv
      - design/busMux.sv
      - design/singleBusDatapath.sv
  - target: test
    files:
      - dv/datapath_chk.sv
      - dv/datapathTb.sv
